/* compile.f */
+incdir+testbench
verilog/rv_pkg.sv
verilog/rv_reg_file.sv
verilog/rv_imm_gen.sv
verilog/rv_alu_ctrl.sv
verilog/rv_branch_unit.sv
verilog/rv_decode.sv
verilog/rv_decode_top.sv
testbench/tb_rv_decode.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and searches the log for a pass

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing -f compile.f --top-module tb_rv_decode -Mdir "$obj" -o tb_rv_decode
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$obj/tb_rv_decode" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

grep -q "^TEST RESULT: PASS$" "$log"
if [ $? -ne 0 ]; then
	echo "Simulation failed, see $log"
	exit 1
fi

echo "Simulation passed"
exit 0

/* testbench/tb_rv_decode_model.svh */
// Reference model with register array, immediate builder, ALU op select, branch decision and target
`ifndef TB_RV_DECODE_MODEL_SVH
`define TB_RV_DECODE_MODEL_SVH

word_t ref_regs [32];  // Expected architectural registers

function automatic void clear_regs();
	for (int i = 0; i < 32; i++) begin
		ref_regs[i] = '0;
	end
endfunction

function automatic word_t read_reg(input reg_addr_t a, input wb_t wb);
	if (a == 5'd0)
		return '0;            // x0 reads zero
	if (wb.wr && (wb.rd == a))
		return wb.data;       // Same-cycle write is visible
	return ref_regs[a];
endfunction

function automatic void write_reg(input wb_t wb);
	if (wb.wr && (wb.rd != 5'd0))
		ref_regs[wb.rd] = wb.data;
endfunction

// Sign-extend the low width bits of raw by shifting up and back arithmetically
function automatic word_t sign_extend(input word_t raw, input int width);
	word_t v;
	v = raw << (32 - width);
	return $signed(v) >>> (32 - width);
endfunction

function automatic word_t expected_imm(input word_t ins);
	case (ins[6:0])
		OP_IMM, OP_LOAD, OP_JALR: return sign_extend(word_t'(ins[31:20]), 12);
		OP_STORE:  return sign_extend(word_t'({ins[31:25], ins[11:7]}), 12);
		OP_BRANCH: return sign_extend(word_t'({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}), 13);
		OP_JAL:    return sign_extend(word_t'({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}), 21);
		OP_LUI, OP_AUIPC: return {ins[31:12], 12'h000};  // Upper immediate
		default:   return '0;                            // R-type has none
	endcase
endfunction

function automatic alu_op_t expected_alu_op(input word_t ins);
	case (ins[6:0])
		OP_LUI:    return ALU_PASS_B;
		OP_BRANCH: return ALU_SUB;
		OP_REG, OP_IMM: begin
			case (ins[14:12])
				3'd0:    return (ins[30] && (ins[6:0] == OP_REG)) ? ALU_SUB : ALU_ADD;
				3'd1:    return ALU_SLL;
				3'd2:    return ALU_SLT;
				3'd3:    return ALU_SLTU;
				3'd4:    return ALU_XOR;
				3'd5:    return ins[30] ? ALU_SRA : ALU_SRL;
				3'd6:    return ALU_OR;
				default: return ALU_AND;
			endcase
		end
		default:   return ALU_ADD;  // Loads, stores, jumps, AUIPC
	endcase
endfunction

function automatic logic branch_taken(input opcode_t op, input func3_t f3, input word_t a,
                                      input word_t b);
	if ((op == OP_JAL) || (op == OP_JALR))
		return 1'b1;
	if (op != OP_BRANCH)
		return 1'b0;
	case (f3)
		3'd0:    return a == b;
		3'd1:    return a != b;
		3'd4:    return $signed(a) < $signed(b);
		3'd5:    return !($signed(a) < $signed(b));
		3'd6:    return a < b;
		3'd7:    return !(a < b);
		default: return 1'b0;
	endcase
endfunction

function automatic word_t branch_target(input opcode_t op, input word_t pc, input word_t a,
                                        input word_t imm);
	if (op == OP_JALR)
		return (a + imm) & 32'hffff_fffe;  // Register-relative, even address
	return pc + imm;
endfunction

`endif

/* testbench/tb_rv_decode.sv */
// Testbench for the decode stage top level with random stimulus and model checks
module tb_rv_decode import rv_pkg::*; ();

	typedef logic [$bits(id_ex_t)-1:0] cmp_t;  // Widest compared value

	typedef struct packed {
		logic  valid;
		word_t instr;
		word_t pc;
		logic  pred;
		logic  stall;
		logic  fwd1;
		logic  fwd2;
		word_t exr;
		wb_t   wb;
	} stim_t;

	logic   clk;
	logic   rst_n;
	logic   i_valid;
	word_t  i_instr;
	word_t  i_pc;
	logic   i_prediction;
	logic   i_stall;
	logic   i_fwd_rs1;
	logic   i_fwd_rs2;
	word_t  i_ex_result;
	wb_t    i_wb;
	id_ex_t o_id_ex;
	logic   o_flush;
	word_t  o_redirect_pc;
	logic   o_stall;

	integer seed;
	int     errors;
	int     checks;
	stim_t  cur;         // Inputs of the current cycle
	id_ex_t exp_bundle;  // Expected ID/EX contents now
	id_ex_t next_exp;    // Captured at the next unstalled edge

	`include "tb_rv_decode_model.svh"

	rv_decode_top u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_valid       (i_valid),
		.i_instr       (i_instr),
		.i_pc          (i_pc),
		.i_prediction  (i_prediction),
		.i_stall       (i_stall),
		.i_fwd_rs1     (i_fwd_rs1),
		.i_fwd_rs2     (i_fwd_rs2),
		.i_ex_result   (i_ex_result),
		.i_wb          (i_wb),
		.o_id_ex       (o_id_ex),
		.o_flush       (o_flush),
		.o_redirect_pc (o_redirect_pc),
		.o_stall       (o_stall)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // Period 40
	end

	task automatic check(input string name, input cmp_t got, input cmp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Random fields under a legal opcode, control flow only when ctrl is set
	function automatic word_t make_instr(input logic ctrl);
		word_t   w;
		opcode_t op;
		func3_t  f3;
		int      pick;
		w    = rand_word();
		pick = ctrl ? 2 + rand_below(3) : rand_below(9);
		case (pick)
			0:       op = OP_LUI;
			1:       op = OP_AUIPC;
			2:       op = OP_JAL;
			3:       op = OP_JALR;
			4:       op = OP_BRANCH;
			5:       op = OP_LOAD;
			6:       op = OP_STORE;
			7:       op = OP_IMM;
			default: op = OP_REG;
		endcase
		f3 = w[14:12];
		case (op)
			OP_BRANCH: begin
				if ((f3 == 3'd2) || (f3 == 3'd3))
					f3[1] = 1'b0;  // Reserved codes folded onto BEQ/BNE
			end
			OP_JALR:  f3 = 3'd0;
			OP_LOAD: begin
				if ((f3 == 3'd3) || (f3 > 3'd5))
					f3 = 3'd2;
			end
			OP_STORE: begin
				if (f3 > 3'd2)
					f3 = 3'd2;
			end
			OP_REG:   w[31:25] = {1'b0, ((f3 == 3'd0) || (f3 == 3'd5)) && w[30], 5'b0};
			OP_IMM: begin
				if ((f3 == 3'd1) || (f3 == 3'd5))
					w[31:25] = {1'b0, (f3 == 3'd5) && w[30], 5'b0};  // Shift-immediate
			end
			default: ;
		endcase
		return {w[31:15], f3, w[11:7], op};
	endfunction

	task automatic compare_bundle();
		check("o_id_ex.valid", cmp_t'(o_id_ex.valid), cmp_t'(exp_bundle.valid));
		if (exp_bundle.valid) begin
			check("o_id_ex.pc", cmp_t'(o_id_ex.pc), cmp_t'(exp_bundle.pc));
			check("o_id_ex.rs1_data", cmp_t'(o_id_ex.rs1_data), cmp_t'(exp_bundle.rs1_data));
			check("o_id_ex.rs2_data", cmp_t'(o_id_ex.rs2_data), cmp_t'(exp_bundle.rs2_data));
			check("o_id_ex.imm", cmp_t'(o_id_ex.imm), cmp_t'(exp_bundle.imm));
			check("o_id_ex.opcode", cmp_t'(o_id_ex.opcode), cmp_t'(exp_bundle.opcode));
			check("o_id_ex.func3", cmp_t'(o_id_ex.func3), cmp_t'(exp_bundle.func3));
			check("o_id_ex.alu_op", cmp_t'(o_id_ex.alu_op), cmp_t'(exp_bundle.alu_op));
			check("o_id_ex.rs1", cmp_t'(o_id_ex.rs1), cmp_t'(exp_bundle.rs1));
			check("o_id_ex.rs2", cmp_t'(o_id_ex.rs2), cmp_t'(exp_bundle.rs2));
			check("o_id_ex.rd", cmp_t'(o_id_ex.rd), cmp_t'(exp_bundle.rd));
			check("o_id_ex.is_jump", cmp_t'(o_id_ex.is_jump), cmp_t'(exp_bundle.is_jump));
		end
	endtask

	// Checks flush and redirect of the current cycle, predicts the next bundle
	task automatic resolve_cycle();
		opcode_t op;
		logic    re;
		logic    taken;
		word_t   d1;
		word_t   d2;
		word_t   a;
		word_t   b;
		word_t   imm;
		word_t   tgt;
		op    = cur.instr[6:0];
		re    = cur.valid && !((op == OP_LUI) || (op == OP_AUIPC) || (op == OP_JAL));
		d1    = re ? read_reg(cur.instr[19:15], cur.wb) : '0;
		d2    = re ? read_reg(cur.instr[24:20], cur.wb) : '0;
		imm   = expected_imm(cur.instr);
		a     = cur.fwd1 ? cur.exr : d1;  // Compare operands after forwarding
		b     = cur.fwd2 ? cur.exr : d2;
		taken = branch_taken(op, cur.instr[14:12], a, b);
		tgt   = branch_target(op, cur.pc, a, imm);
		check("o_flush", cmp_t'(o_flush), cmp_t'(cur.valid && (cur.pred != taken)));
		check("o_stall", cmp_t'(o_stall), cmp_t'(cur.stall));
		if (cur.valid)
			check("o_redirect_pc", cmp_t'(o_redirect_pc), cmp_t'(taken ? tgt : cur.pc + 32'd4));
		next_exp.valid    = cur.valid;
		next_exp.pc       = cur.pc;
		next_exp.rs1_data = d1;  // Register values without EX forward
		next_exp.rs2_data = d2;
		next_exp.imm      = imm;
		next_exp.opcode   = op;
		next_exp.func3    = cur.instr[14:12];
		next_exp.alu_op   = expected_alu_op(cur.instr);
		next_exp.rs1      = cur.instr[19:15];
		next_exp.rs2      = cur.instr[24:20];
		next_exp.rd       = cur.instr[11:7];
		next_exp.is_jump  = (op == OP_JAL) || (op == OP_JALR);
	endtask

	// One clock cycle: drive at the rising edge, check at the falling edge
	task apply_cycle(input stim_t s);
		@(posedge clk);
		write_reg(cur.wb);       // Write landed at this edge
		if (!cur.stall)
			exp_bundle = next_exp;
		i_valid      <= s.valid;
		i_instr      <= s.instr;
		i_pc         <= s.pc;
		i_prediction <= s.pred;
		i_stall      <= s.stall;
		i_fwd_rs1    <= s.fwd1;
		i_fwd_rs2    <= s.fwd2;
		i_ex_result  <= s.exr;
		i_wb         <= s.wb;
		cur = s;
		@(negedge clk);
		compare_bundle();
		resolve_cycle();
	endtask

	task automatic random_cycles(input int n, input int ctrl_pct, input int stall_pct,
	                             input int valid_pct);
		stim_t s;
		word_t r;
		for (int k = 0; k < n; k++) begin
			r         = rand_word();
			s.instr   = make_instr(rand_below(100) < ctrl_pct);
			s.valid   = rand_below(100) < valid_pct;
			s.pc      = rand_word() & 32'hffff_fffc;
			s.pred    = r[7];
			s.stall   = rand_below(100) < stall_pct;
			s.fwd1    = r[5];
			s.fwd2    = r[6];
			s.exr     = rand_word();
			s.wb.wr   = rand_below(4) != 0;
			s.wb.rd   = (rand_below(3) == 0) ? s.instr[19:15] : r[4:0];  // Bypass often
			if (rand_below(10) == 0)
				s.wb.rd = 5'd0;
			s.wb.data = rand_word();
			apply_cycle(s);
		end
	endtask

	initial begin
		stim_t s;
		seed   = 32'h9f1a;
		errors = 0;
		checks = 0;
		clear_regs();
		rst_n        <= 1'b0;
		i_valid      <= 1'b0;
		i_instr      <= '0;
		i_pc         <= '0;
		i_prediction <= 1'b0;
		i_stall      <= 1'b0;
		i_fwd_rs1    <= 1'b0;
		i_fwd_rs2    <= 1'b0;
		i_ex_result  <= '0;
		i_wb         <= '0;
		@(posedge clk);
		@(negedge clk);
		check("o_id_ex", cmp_t'(o_id_ex), '0);  // Empty bundle in reset
		check("o_flush", cmp_t'(o_flush), '0);
		@(posedge clk);
		rst_n <= 1'b1;           // Second edge ends reset
		cur        = '0;
		exp_bundle = '0;
		next_exp   = '0;
		for (int r = 0; r < 32; r++) begin
			s       = '0;
			s.valid = 1'b1;
			s.pc    = 32'h0000_1000;
			s.instr = {7'd0, reg_addr_t'(31 - r), reg_addr_t'(r), 3'd0, 5'd1, OP_REG};
			apply_cycle(s);
		end
		random_cycles(200, 0, 0, 100);    // Writeback traffic and plain decode
		random_cycles(300, 50, 0, 100);   // Branches and jumps with forwarding
		random_cycles(200, 30, 40, 100);  // Stall runs with changing inputs
		random_cycles(100, 30, 20, 50);   // Empty slots
		s = '0;
		apply_cycle(s);          // Checks the last captured bundle
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : watchdog
		for (int c = 0; c < 5000; c++) begin
			@(posedge clk);
		end
		$display("Timeout: the test did not finish within 5000 clock cycles");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* verilog/rv_decode_top.sv */
// Decode stage top level with register file and decode stage instances
module rv_decode_top import rv_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   i_valid,       // IF/ID slot occupied
	input  word_t  i_instr,
	input  word_t  i_pc,
	input  logic   i_prediction,
	input  logic   i_stall,       // From execute hazard unit
	input  logic   i_fwd_rs1,
	input  logic   i_fwd_rs2,
	input  word_t  i_ex_result,
	input  wb_t    i_wb,          // Writeback register write
	output id_ex_t o_id_ex,
	output logic   o_flush,       // To fetch
	output word_t  o_redirect_pc,
	output logic   o_stall        // Stall passed back to fetch
);

	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	logic      re;
	word_t     rs1_data;
	word_t     rs2_data;

	assign o_stall = i_stall;

	rv_reg_file u_reg_file (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_re       (re),
		.i_rs1_addr (rs1_addr),
		.i_rs2_addr (rs2_addr),
		.i_wb       (i_wb),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	rv_decode u_decode (
		.clk (clk), .rst_n (rst_n),
		.i_valid (i_valid), .i_instr (i_instr), .i_pc (i_pc),
		.i_prediction (i_prediction), .i_stall (i_stall),
		.i_fwd_rs1 (i_fwd_rs1), .i_fwd_rs2 (i_fwd_rs2), .i_ex_result (i_ex_result),
		.i_rs1_data (rs1_data), .i_rs2_data (rs2_data),
		.o_rs1_addr (rs1_addr), .o_rs2_addr (rs2_addr), .o_re (re),
		.o_id_ex (o_id_ex), .o_flush (o_flush), .o_redirect_pc (o_redirect_pc)
	);

endmodule

/* verilog/rv_decode.sv */
// Decode stage with field split, branch forwarding, flush and redirect, ID/EX register
module rv_decode import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      i_valid,       // From IF/ID
	input  word_t     i_instr,
	input  word_t     i_pc,
	input  logic      i_prediction,  // Fetch predicted taken
	input  logic      i_stall,       // Freezes ID/EX
	input  logic      i_fwd_rs1,     // Use EX result for rs1 compare
	input  logic      i_fwd_rs2,
	input  word_t     i_ex_result,
	input  word_t     i_rs1_data,    // From register file
	input  word_t     i_rs2_data,
	output reg_addr_t o_rs1_addr,
	output reg_addr_t o_rs2_addr,
	output logic      o_re,
	output id_ex_t    o_id_ex,
	output logic      o_flush,
	output word_t     o_redirect_pc
);

	word_t     instr;     // Decoded word, NOP when slot is empty
	opcode_t   opcode;
	func3_t    func3;
	reg_addr_t rd;
	word_t     imm;
	alu_op_t   alu_op;
	word_t     rs1_cmp;   // Branch operands after forwarding
	word_t     rs2_cmp;
	br_t       br;
	logic      no_read;   // Formats without source registers
	id_ex_t    id_ex_d;

	// Field split
	assign instr      = i_valid ? i_instr : NOP_INSTR;
	assign opcode     = instr[6:0];
	assign func3      = instr[14:12];
	assign rd         = instr[11:7];
	assign o_rs1_addr = instr[19:15];
	assign o_rs2_addr = instr[24:20];

	assign no_read = (opcode == OP_LUI) || (opcode == OP_AUIPC) || (opcode == OP_JAL);
	assign o_re    = i_valid & ~no_read;

	rv_imm_gen u_imm_gen (
		.i_instr (instr),
		.o_imm   (imm)
	);

	rv_alu_ctrl u_alu_ctrl (
		.i_instr  (instr),
		.o_alu_op (alu_op)
	);

	assign rs1_cmp = i_fwd_rs1 ? i_ex_result : i_rs1_data;  // EX forward for compare
	assign rs2_cmp = i_fwd_rs2 ? i_ex_result : i_rs2_data;

	rv_branch_unit u_branch_unit (
		.i_opcode   (opcode),
		.i_func3    (func3),
		.i_rs1_data (rs1_cmp),
		.i_rs2_data (rs2_cmp),
		.i_pc       (i_pc),
		.i_imm      (imm),
		.o_br       (br)
	);

	// Wrong prediction either way redirects fetch to the resolved path
	assign o_flush       = i_valid & (i_prediction ^ br.taken);
	assign o_redirect_pc = br.taken ? br.target : (i_pc + 32'd4);

	// Next ID/EX contents
	always_comb begin
		id_ex_d.valid    = i_valid;
		id_ex_d.pc       = i_pc;
		id_ex_d.rs1_data = i_rs1_data;  // Register values, execute forwards again
		id_ex_d.rs2_data = i_rs2_data;
		id_ex_d.imm      = imm;
		id_ex_d.opcode   = opcode;
		id_ex_d.func3    = func3;
		id_ex_d.alu_op   = alu_op;
		id_ex_d.rs1      = o_rs1_addr;
		id_ex_d.rs2      = o_rs2_addr;
		id_ex_d.rd       = rd;
		id_ex_d.is_jump  = (opcode == OP_JAL) || (opcode == OP_JALR);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_id_ex <= '0;       // Empty bundle, valid low
		else if (!i_stall)
			o_id_ex <= id_ex_d;  // Hold while stalled
	end

endmodule

/* verilog/rv_branch_unit.sv */
// Branch condition evaluation, jump detection and target address adder
module rv_branch_unit import rv_pkg::*; (
	input  opcode_t i_opcode,
	input  func3_t  i_func3,
	input  word_t   i_rs1_data,   // Operands after forwarding
	input  word_t   i_rs2_data,
	input  word_t   i_pc,
	input  word_t   i_imm,
	output br_t     o_br
);

	logic  is_jal;
	logic  is_jalr;
	logic  is_branch;
	logic  cond;     // func3 comparison result
	word_t base;     // rs1 for JALR, PC otherwise
	word_t sum;

	assign is_jal    = (i_opcode == OP_JAL);
	assign is_jalr   = (i_opcode == OP_JALR);
	assign is_branch = (i_opcode == OP_BRANCH);

	always_comb begin
		case (i_func3)
			3'b000:  cond = (i_rs1_data == i_rs2_data);                    // BEQ
			3'b001:  cond = (i_rs1_data != i_rs2_data);                    // BNE
			3'b100:  cond = ($signed(i_rs1_data) < $signed(i_rs2_data));   // BLT
			3'b101:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));  // BGE
			3'b110:  cond = (i_rs1_data < i_rs2_data);                     // BLTU
			3'b111:  cond = (i_rs1_data >= i_rs2_data);                    // BGEU
			default: cond = 1'b0;  // Reserved encodings never branch
		endcase
	end

	assign base = is_jalr ? i_rs1_data : i_pc;
	assign sum  = base + i_imm;

	assign o_br.taken  = is_jal | is_jalr | (is_branch & cond);
	assign o_br.target = is_jalr ? {sum[31:1], 1'b0} : sum;  // JALR clears bit 0

endmodule

/* verilog/rv_alu_ctrl.sv */
// ALU operation select from opcode, func3 and funct7 bit 30
module rv_alu_ctrl import rv_pkg::*; (
	input  word_t   i_instr,
	output alu_op_t o_alu_op
);

	opcode_t opcode;
	func3_t  func3;
	logic    bit30;  // funct7[5], SUB and SRA select

	assign opcode = i_instr[6:0];
	assign func3  = i_instr[14:12];
	assign bit30  = i_instr[30];

	// Shared func3 mapping, SUB only allowed for register-register ops
	function automatic alu_op_t arith_op(input func3_t f3, input logic b30,
	                                     input logic is_reg);
		alu_op_t op;
		case (f3)
			3'b000:  op = (is_reg && b30) ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = b30 ? ALU_SRA : ALU_SRL;  // SRAI too
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		case (opcode)
			OP_REG:    o_alu_op = arith_op(func3, bit30, 1'b1);
			OP_IMM:    o_alu_op = arith_op(func3, bit30, 1'b0);
			OP_BRANCH: o_alu_op = ALU_SUB;     // Compare by subtraction
			OP_LUI:    o_alu_op = ALU_PASS_B;  // Immediate goes straight to rd
			OP_LOAD, OP_STORE, OP_JAL, OP_JALR, OP_AUIPC: begin
				o_alu_op = ALU_ADD;  // Address or PC sums
			end
			default:   o_alu_op = ALU_ADD;
		endcase
	end

endmodule

/* verilog/rv_imm_gen.sv */
// Immediate generator for the I, S, B, U and J instruction formats
module rv_imm_gen import rv_pkg::*; (
	input  word_t i_instr,
	output word_t o_imm
);

	opcode_t opcode;
	logic    sign;  // Instruction bit 31 is the sign in every format

	assign opcode = i_instr[6:0];
	assign sign   = i_instr[31];

	always_comb begin
		case (opcode)
			OP_IMM, OP_LOAD, OP_JALR: begin
				o_imm = {{20{sign}}, i_instr[31:20]};  // I-type
			end
			OP_STORE: begin
				o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};  // S-type
			end
			OP_BRANCH: begin
				// B-type, offset in units of two bytes
				o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25],
				         i_instr[11:8], 1'b0};
			end
			OP_LUI, OP_AUIPC: begin
				o_imm = {i_instr[31:12], 12'b0};  // U-type, upper 20 bits
			end
			OP_JAL: begin
				o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20],
				         i_instr[30:21], 1'b0};  // J-type
			end
			default: begin
				o_imm = '0;  // R-type and unknown opcodes
			end
		endcase
	end

endmodule

/* verilog/rv_reg_file.sv */
// Register file with 32 x 32-bit registers, two bypassed read ports and one write port
module rv_reg_file import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      i_re,          // Read enable, low gives zero data
	input  reg_addr_t i_rs1_addr,
	input  reg_addr_t i_rs2_addr,
	input  wb_t       i_wb,          // Write port from writeback
	output word_t     o_rs1_data,
	output word_t     o_rs2_data
);

	word_t regs [32];  // Architectural state
	logic  wr_ok;      // Write that actually lands

	assign wr_ok = i_wb.wr && (i_wb.rd != 5'd0);  // x0 stays zero

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[i_wb.rd] <= i_wb.data;
		end
	end

	// Combinational reads, a write in the same cycle is forwarded
	always_comb begin
		o_rs1_data = '0;
		o_rs2_data = '0;
		if (i_re) begin
			if (i_rs1_addr == 5'd0)
				o_rs1_data = '0;                        // Hardwired zero
			else if (wr_ok && (i_wb.rd == i_rs1_addr))
				o_rs1_data = i_wb.data;                 // Write-through
			else
				o_rs1_data = regs[i_rs1_addr];
			if (i_rs2_addr == 5'd0)
				o_rs2_data = '0;
			else if (wr_ok && (i_wb.rd == i_rs2_addr))
				o_rs2_data = i_wb.data;
			else
				o_rs2_data = regs[i_rs2_addr];
		end
	end

endmodule

/* verilog/rv_pkg.sv */
// RV32I decode package with word and field typedefs, opcode and ALU codes, pipeline structs
package rv_pkg;

	typedef logic [31:0] word_t;      // Data, address or instruction word
	typedef logic [4:0]  reg_addr_t;  // Register index x0..x31
	typedef logic [6:0]  opcode_t;    // Major opcode, instr[6:0]
	typedef logic [2:0]  func3_t;     // Function field, instr[14:12]
	typedef logic [3:0]  alu_op_t;    // Operation code handed to execute

	// Major opcodes of the RV32I base set
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_IMM    = 7'b0010011;  // Register-immediate arithmetic
	localparam opcode_t OP_REG    = 7'b0110011;  // Register-register arithmetic

	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_SLL    = 4'd2;
	localparam alu_op_t ALU_SLT    = 4'd3;
	localparam alu_op_t ALU_SLTU   = 4'd4;
	localparam alu_op_t ALU_XOR    = 4'd5;
	localparam alu_op_t ALU_SRL    = 4'd6;
	localparam alu_op_t ALU_SRA    = 4'd7;
	localparam alu_op_t ALU_OR     = 4'd8;
	localparam alu_op_t ALU_AND    = 4'd9;
	localparam alu_op_t ALU_PASS_B = 4'd10;  // Operand B straight through, for LUI

	localparam word_t NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

	// ID/EX pipeline bundle, 159 bits
	typedef struct packed {
		logic      valid;
		word_t     pc;
		word_t     rs1_data;
		word_t     rs2_data;
		word_t     imm;
		opcode_t   opcode;
		func3_t    func3;
		alu_op_t   alu_op;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic      is_jump;   // JAL or JALR, execute writes PC+4 to rd
	} id_ex_t;

	typedef struct packed {
		logic      wr;     // Write strobe from writeback
		reg_addr_t rd;
		word_t     data;
	} wb_t;

	typedef struct packed {
		logic  taken;   // Branch condition holds or jump
		word_t target;
	} br_t;

endpackage
